/* design/mmu_cfg.svh */
// Memory stage configuration
// Address, tag, data and table sizes shared by the package and RTL

`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Sv39 virtual address split
`define MMU_VADDR_W 39
`define MMU_PGOFF_W 12
`define MMU_VTAG_W 27

// Physical page tag kept in each TLB entry
`define MMU_PTAG_W 16

`define MMU_DWORD_W 64

`define MMU_TLB_ELS 4

// Scratchpad index is ptag[0] followed by offset[11:3]
`define MMU_RAM_IDX_W 10

`endif

/* design/mmu_pkg.sv */
// Memory stage types
// Opcodes, privilege levels, exception codes and the packed buses

`include "mmu_cfg.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    e_op_ld     = 2'b00,
    e_op_sd     = 2'b01,
    e_op_sfence = 2'b10
  } mem_op_e;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_s = 2'b01,
    e_priv_m = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    e_exc_none      = 2'b00,
    e_exc_tlb_miss  = 2'b01,
    e_exc_load_pf   = 2'b10,
    e_exc_store_pf  = 2'b11
  } exc_e;

  typedef struct packed {
    mem_op_e                  op;
    logic [`MMU_VADDR_W-1:0]  vaddr;
    logic [`MMU_DWORD_W-1:0]  data;
  } mmu_cmd_s;

  // Leaf PTE bits needed for data accesses
  typedef struct packed {
    logic [`MMU_PTAG_W-1:0] ptag;
    logic                   u;
    logic                   w;
    logic                   d;
  } tlb_entry_s;

  typedef struct packed {
    logic [`MMU_VTAG_W-1:0] vtag;
    tlb_entry_s             entry;
  } tlb_fill_s;

  typedef struct packed {
    exc_e                    exc;
    logic [`MMU_DWORD_W-1:0] data;
  } mem_resp_s;

endpackage

/* design/data_ram.sv */
// Doubleword scratchpad RAM
// Single port, synchronous read-before-write

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module data_ram
  (input                             clk_i
   , input                           we_i
   , input  [`MMU_RAM_IDX_W-1:0]     idx_i
   , input  [`MMU_DWORD_W-1:0]       wdata_i
   , output [`MMU_DWORD_W-1:0]       rdata_o
   );

  localparam int depth = 1 << `MMU_RAM_IDX_W;

  logic [`MMU_DWORD_W-1:0] mem [depth];
  logic [`MMU_DWORD_W-1:0] rdata_r;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[idx_i] <= wdata_i;
    end
    // Old contents on a same-cycle write
    rdata_r <= mem[idx_i];
  end

  assign rdata_o = rdata_r;

endmodule

/* design/dtlb.sv */
// Data TLB
// Four-entry fully associative CAM, round-robin fill, registered lookup

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module dtlb
  import mmu_pkg::*;
  (input                            clk_i
   , input                          reset_i

   , input  [`MMU_VTAG_W-1:0]       lookup_vtag_i

   , input                          fill_v_i
   , input  tlb_fill_s              fill_i
   , input                          flush_i

   , input                          translation_en_i

   , output                         hit_o
   , output tlb_entry_s             entry_o
   );

  localparam int ptr_w = $clog2(`MMU_TLB_ELS);

  logic [`MMU_TLB_ELS-1:0] valid_r;
  logic [`MMU_VTAG_W-1:0]  tag_r   [`MMU_TLB_ELS];
  tlb_entry_s              entry_r [`MMU_TLB_ELS];
  logic [ptr_w-1:0]        rr_ptr_r;

  logic [`MMU_TLB_ELS-1:0] lookup_match;
  logic [`MMU_TLB_ELS-1:0] fill_match;
  logic [ptr_w-1:0]        lookup_idx;
  logic [ptr_w-1:0]        fill_idx;
  logic                    fill_hit;

  logic                    hit_r;
  tlb_entry_s              hit_entry_r;

  always_comb begin
    lookup_idx = '0;
    fill_idx   = rr_ptr_r;
    for (int i = 0; i < `MMU_TLB_ELS; i++) begin
      lookup_match[i] = valid_r[i] && (tag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] && (tag_r[i] == fill_i.vtag);
      if (lookup_match[i]) begin
        lookup_idx = ptr_w'(i);
      end
      if (fill_match[i]) begin
        fill_idx = ptr_w'(i);
      end
    end
  end

  assign fill_hit = |fill_match;

  // Fill wins over a same-cycle flush for its own slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
    end else begin
      if (flush_i) begin
        valid_r <= '0;
      end
      if (fill_v_i) begin
        valid_r[fill_idx] <= 1'b1;
        if (!fill_hit) begin
          rr_ptr_r <= rr_ptr_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx]   <= fill_i.vtag;
      entry_r[fill_idx] <= fill_i.entry;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_r <= 1'b0;
    end else begin
      hit_r <= !translation_en_i || (|lookup_match);
    end
  end

  always_ff @(posedge clk_i) begin
    hit_entry_r <= entry_r[lookup_idx];
  end

  assign hit_o   = hit_r;
  assign entry_o = hit_entry_r;

  // Refill in place keeps tags unique across entries
  a_onehot_match: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(lookup_match)
  );

endmodule

/* design/fault_check.sv */
// Sv39 leaf permission check for loads and stores
// Also forms the scratchpad index from the physical or virtual page

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module fault_check
  import mmu_pkg::*;
  (input  mmu_cmd_s                   s1_cmd_i
   , input  tlb_entry_s               entry_i
   , input  priv_e                    priv_i
   , input                            sum_i
   , input                            translation_en_i

   , output exc_e                     fault_o
   , output [`MMU_RAM_IDX_W-1:0]      ram_idx_o
   );

  logic priv_fault;
  logic write_fault;
  logic check_en;
  logic ptag_lsb;

  assign priv_fault = ((priv_i == e_priv_u) && !entry_i.u)
                    | ((priv_i == e_priv_s) && entry_i.u && !sum_i);
  assign write_fault = !entry_i.w || !entry_i.d;

  // Bare mode and M mode skip the check
  assign check_en = translation_en_i && (priv_i != e_priv_m);

  always_comb begin
    fault_o = e_exc_none;
    if (check_en) begin
      if ((s1_cmd_i.op == e_op_sd) && (priv_fault || write_fault)) begin
        fault_o = e_exc_store_pf;
      end else if ((s1_cmd_i.op == e_op_ld) && priv_fault) begin
        fault_o = e_exc_load_pf;
      end
    end
  end

  assign ptag_lsb  = translation_en_i ? entry_i.ptag[0] : s1_cmd_i.vaddr[`MMU_PGOFF_W];
  assign ram_idx_o = {ptag_lsb, s1_cmd_i.vaddr[`MMU_PGOFF_W-1:3]};

endmodule

/* design/mem_ctrl.sv */
// Memory stage control
// Two-stage valid pipeline, poison kill, exception select and response

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mem_ctrl
  import mmu_pkg::*;
  (input                             clk_i
   , input                           reset_i

   , input                           cmd_v_i
   , input  mmu_cmd_s                cmd_i
   , input                           poison_i

   , input                           tlb_hit_i
   , input  exc_e                    fault_i
   , input  [`MMU_DWORD_W-1:0]       ram_data_i

   , output mmu_cmd_s                s1_cmd_o
   , output                          ram_we_o
   , output                          flush_o

   , output                          resp_v_o
   , output mem_resp_s               resp_o
   );

  logic     s1_v_r;
  mmu_cmd_s s1_cmd_r;
  logic     s1_live;
  exc_e     s1_exc;

  logic     s2_v_r;
  exc_e     s2_exc_r;
  logic     s2_rd_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_cmd_r <= cmd_i;
  end

  assign s1_live = s1_v_r & ~poison_i;

  // Miss takes priority over permission faults
  always_comb begin
    s1_exc = e_exc_none;
    if (s1_cmd_r.op != e_op_sfence) begin
      if (!tlb_hit_i) begin
        s1_exc = e_exc_tlb_miss;
      end else begin
        s1_exc = fault_i;
      end
    end
  end

  assign ram_we_o = s1_live && (s1_cmd_r.op == e_op_sd) && (s1_exc == e_exc_none);
  assign flush_o  = s1_live && (s1_cmd_r.op == e_op_sfence);
  assign s1_cmd_o = s1_cmd_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_r <= 1'b0;
    end else begin
      s2_v_r <= s1_live;
    end
  end

  always_ff @(posedge clk_i) begin
    s2_exc_r <= s1_exc;
    s2_rd_r  <= (s1_cmd_r.op == e_op_ld) && (s1_exc == e_exc_none);
  end

  assign resp_v_o    = s2_v_r;
  assign resp_o.exc  = s2_exc_r;
  assign resp_o.data = s2_rd_r ? ram_data_i : '0;

  // Every response comes from a command accepted two cycles earlier and not killed
  a_resp_from_live_cmd: assert property (
    @(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> ($past(cmd_v_i, 2) && !$past(poison_i))
  );

endmodule

/* design/mem_stage_top.sv */
// Memory stage top level
// Control pipeline with the data TLB, permission check and scratchpad RAM

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mem_stage_top
  import mmu_pkg::*;
  (input                clk_i
   , input              reset_i

   , input              cmd_v_i
   , input  mmu_cmd_s   cmd_i

   , input              fill_v_i
   , input  tlb_fill_s  fill_i

   , input              poison_i

   , input  priv_e      priv_i
   , input              translation_en_i
   , input              sum_i

   , output             resp_v_o
   , output mem_resp_s  resp_o
   );

  mmu_cmd_s                  s1_cmd;
  logic                      tlb_hit;
  tlb_entry_s                tlb_entry;
  exc_e                      fault;
  logic                      ram_we;
  logic                      tlb_flush;
  logic [`MMU_RAM_IDX_W-1:0] ram_idx;
  logic [`MMU_DWORD_W-1:0]   ram_rdata;

  mem_ctrl ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_i(cmd_i)
     ,.poison_i(poison_i)
     ,.tlb_hit_i(tlb_hit)
     ,.fault_i(fault)
     ,.ram_data_i(ram_rdata)
     ,.s1_cmd_o(s1_cmd)
     ,.ram_we_o(ram_we)
     ,.flush_o(tlb_flush)
     ,.resp_v_o(resp_v_o)
     ,.resp_o(resp_o)
     );

  // Lookup runs in the accept cycle on the incoming vtag
  dtlb tlb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.lookup_vtag_i(cmd_i.vaddr[`MMU_VADDR_W-1:`MMU_PGOFF_W])
     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)
     ,.flush_i(tlb_flush)
     ,.translation_en_i(translation_en_i)
     ,.hit_o(tlb_hit)
     ,.entry_o(tlb_entry)
     );

  fault_check chk
    (.s1_cmd_i(s1_cmd)
     ,.entry_i(tlb_entry)
     ,.priv_i(priv_i)
     ,.sum_i(sum_i)
     ,.translation_en_i(translation_en_i)
     ,.fault_o(fault)
     ,.ram_idx_o(ram_idx)
     );

  data_ram ram
    (.clk_i(clk_i)
     ,.we_i(ram_we)
     ,.idx_i(ram_idx)
     ,.wdata_i(s1_cmd.data)
     ,.rdata_o(ram_rdata)
     );

endmodule

/* testbench/tb_vectors.svh */
// Stimulus table for the memory stage testbench
// fill_row(vtag, ptag, u, w, d)
// cmd_row(op, vtag, offset, priv, translation, sum, poison, expected exc)
// idle_row() keeps the privilege and translation inputs as they were

// Supervisor, user, read-only and clean pages
fill_row('h10, 'h01, 0, 1, 1);
fill_row('h20, 'h02, 1, 1, 1);
fill_row('h30, 'h03, 0, 0, 1);
fill_row('h40, 'h04, 0, 1, 0);
cmd_row(e_op_sd, 'h10, 'h008, e_priv_s, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h10, 'h008, e_priv_s, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h55, 'h000, e_priv_s, 1, 0, 0, e_exc_tlb_miss);
// Read-only page aliases the first store
cmd_row(e_op_sd, 'h30, 'h008, e_priv_s, 1, 0, 0, e_exc_store_pf);
cmd_row(e_op_ld, 'h30, 'h008, e_priv_s, 1, 0, 0, e_exc_none);
idle_row();
cmd_row(e_op_sd, 'h20, 'h010, e_priv_u, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h10, 'h010, e_priv_u, 1, 0, 0, e_exc_load_pf);
cmd_row(e_op_sd, 'h10, 'h010, e_priv_u, 1, 0, 0, e_exc_store_pf);
idle_row();
cmd_row(e_op_ld, 'h20, 'h010, e_priv_s, 1, 0, 0, e_exc_load_pf);
cmd_row(e_op_sd, 'h20, 'h010, e_priv_s, 1, 0, 0, e_exc_store_pf);
idle_row();
// SUM set and a store to the clean page
cmd_row(e_op_ld, 'h20, 'h010, e_priv_s, 1, 1, 0, e_exc_none);
cmd_row(e_op_sd, 'h40, 'h010, e_priv_s, 1, 1, 0, e_exc_store_pf);
cmd_row(e_op_ld, 'h40, 'h010, e_priv_s, 1, 1, 0, e_exc_none);
idle_row();
cmd_row(e_op_sd, 'h30, 'h018, e_priv_m, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h30, 'h018, e_priv_m, 1, 0, 0, e_exc_none);
cmd_row(e_op_sd, 'h20, 'h018, e_priv_m, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h40, 'h018, e_priv_m, 1, 0, 0, e_exc_none);
idle_row();
// Poisoned store then the old data
cmd_row(e_op_sd, 'h10, 'h008, e_priv_s, 1, 0, 1, e_exc_none);
cmd_row(e_op_ld, 'h10, 'h008, e_priv_s, 1, 0, 0, e_exc_none);
cmd_row(e_op_sfence, 'h00, 'h000, e_priv_s, 1, 0, 0, e_exc_none);
idle_row();
cmd_row(e_op_ld, 'h10, 'h008, e_priv_s, 1, 0, 0, e_exc_tlb_miss);
idle_row();
// Bare mode takes the index from vaddr bit 12
cmd_row(e_op_sd, 'h01, 'h020, e_priv_u, 0, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h01, 'h020, e_priv_u, 0, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h02, 'h010, e_priv_u, 0, 0, 0, e_exc_none);
fill_row('h61, 'h11, 0, 1, 1);
fill_row('h62, 'h12, 0, 1, 1);
fill_row('h63, 'h13, 0, 1, 1);
fill_row('h64, 'h14, 0, 1, 1);
fill_row('h65, 'h15, 0, 1, 1);
cmd_row(e_op_ld, 'h61, 'h000, e_priv_s, 1, 0, 0, e_exc_tlb_miss);
cmd_row(e_op_sd, 'h65, 'h028, e_priv_s, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h65, 'h028, e_priv_s, 1, 0, 0, e_exc_none);
// Refill in place while the pointer sits on the 0x62 slot
fill_row('h64, 'h16, 0, 0, 1);
cmd_row(e_op_sd, 'h64, 'h010, e_priv_s, 1, 0, 0, e_exc_store_pf);
cmd_row(e_op_ld, 'h64, 'h010, e_priv_s, 1, 0, 0, e_exc_none);
cmd_row(e_op_ld, 'h62, 'h010, e_priv_s, 1, 0, 0, e_exc_none);

/* testbench/tb_mem_stage.sv */
// Testbench for the memory stage
// Applies a table of TLB fills and commands and checks every response

`timescale 1ns/1ns
`include "mmu_cfg.svh"

module tb_mem_stage
  import mmu_pkg::*;
  ();

  typedef enum logic [1:0] {
    e_row_idle = 2'b00,
    e_row_fill = 2'b01,
    e_row_cmd  = 2'b10
  } row_kind_e;

  typedef struct packed {
    row_kind_e               kind;
    tlb_fill_s               fill;
    mem_op_e                 op;
    logic [`MMU_VADDR_W-1:0] vaddr;
    priv_e                   priv;
    logic                    trans;
    logic                    sum;
    logic                    poison;
    exc_e                    exc;
  } row_s;

  typedef struct packed {
    int        due;
    mem_resp_s resp;
  } expect_s;

  logic      clk_i;
  logic      reset_i;
  logic      cmd_v_i;
  mmu_cmd_s  cmd_i;
  logic      fill_v_i;
  tlb_fill_s fill_i;
  logic      poison_i;
  priv_e     priv_i;
  logic      translation_en_i;
  logic      sum_i;
  logic      resp_v_o;
  mem_resp_s resp_o;

  row_s                    rows [$];
  expect_s                 expect_q [$];
  expect_s                 exp_head;
  logic [`MMU_DWORD_W-1:0] model [1 << `MMU_RAM_IDX_W];
  logic [`MMU_PTAG_W-1:0]  page_map [logic [`MMU_VTAG_W-1:0]];
  logic [31:0]             lfsr_state = 32'h0b0e1a92;
  int                      cycle_cnt = 0;
  int                      cycle_limit = 1000;

  mem_stage_top dut_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_i(cmd_i)
     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)
     ,.poison_i(poison_i)
     ,.priv_i(priv_i)
     ,.translation_en_i(translation_en_i)
     ,.sum_i(sum_i)
     ,.resp_v_o(resp_v_o)
     ,.resp_o(resp_o)
     );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic void fill_row(input logic [`MMU_VTAG_W-1:0] vtag,
                                   input logic [`MMU_PTAG_W-1:0] ptag,
                                   input logic u, input logic w, input logic d);
    row_s r;
    r                  = '0;
    r.kind             = e_row_fill;
    r.fill.vtag        = vtag;
    r.fill.entry.ptag  = ptag;
    r.fill.entry.u     = u;
    r.fill.entry.w     = w;
    r.fill.entry.d     = d;
    rows.push_back(r);
  endfunction

  function automatic void cmd_row(input mem_op_e op, input logic [`MMU_VTAG_W-1:0] vtag,
                                  input logic [`MMU_PGOFF_W-1:0] offset, input priv_e priv,
                                  input logic trans, input logic sum, input logic poison,
                                  input exc_e exc);
    row_s r;
    r        = '0;
    r.kind   = e_row_cmd;
    r.op     = op;
    r.vaddr  = {vtag, offset};
    r.priv   = priv;
    r.trans  = trans;
    r.sum    = sum;
    r.poison = poison;
    r.exc    = exc;
    rows.push_back(r);
  endfunction

  function automatic void idle_row();
    row_s r;
    r = '0;
    rows.push_back(r);
  endfunction

  task automatic load_vectors();
    `include "tb_vectors.svh"
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  task automatic next_store_data(output logic [`MMU_DWORD_W-1:0] data);
    for (int b = 0; b < `MMU_DWORD_W; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      data[b]    = lfsr_state[0];
    end
  endtask

  // Physical page bit 0 then doubleword offset
  function automatic logic [`MMU_RAM_IDX_W-1:0] ram_index(input row_s r);
    logic [`MMU_VTAG_W-1:0] vtag;
    logic [`MMU_PTAG_W-1:0] ptag;
    logic                   page_lsb;
    vtag     = r.vaddr[`MMU_VADDR_W-1:`MMU_PGOFF_W];
    page_lsb = r.vaddr[`MMU_PGOFF_W];
    if (r.trans && page_map.exists(vtag)) begin
      ptag     = page_map[vtag];
      page_lsb = ptag[0];
    end
    return {page_lsb, r.vaddr[`MMU_PGOFF_W-1:3]};
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
      stop_on_error();
    end
  endtask

  // Poison belongs to the previous row, whose command is now in stage 1
  task automatic apply_row(input row_s r, input logic poison);
    logic [`MMU_DWORD_W-1:0]   data;
    logic [`MMU_RAM_IDX_W-1:0] idx;
    expect_s                   item;
    poison_i = poison;
    cmd_v_i  = 1'b0;
    fill_v_i = 1'b0;
    data     = '0;
    if (r.kind == e_row_fill) begin
      fill_v_i              = 1'b1;
      fill_i                = r.fill;
      page_map[r.fill.vtag] = r.fill.entry.ptag;
    end else if (r.kind == e_row_cmd) begin
      if (r.op == e_op_sd) begin
        next_store_data(data);
      end
      idx              = ram_index(r);
      cmd_v_i          = 1'b1;
      cmd_i.op         = r.op;
      cmd_i.vaddr      = r.vaddr;
      cmd_i.data       = data;
      priv_i           = r.priv;
      translation_en_i = r.trans;
      sum_i            = r.sum;
      if (!r.poison) begin
        item.due       = cycle_cnt + 2;
        item.resp.exc  = r.exc;
        item.resp.data = '0;
        if (r.op == e_op_ld && r.exc == e_exc_none) begin
          item.resp.data = model[idx];
        end
        if (r.op == e_op_sd && r.exc == e_exc_none) begin
          model[idx] = data;
        end
        expect_q.push_back(item);
      end
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles with responses still outstanding", cycle_cnt);
      stop_on_error();
    end
  end

  // Responses are stable mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (expect_q.size() != 0 && expect_q[0].due == cycle_cnt && !resp_v_o) begin
        $display("No response in cycle %0d for a command issued two cycles earlier",
                 cycle_cnt);
        stop_on_error();
      end else if (resp_v_o) begin
        if (expect_q.size() == 0 || expect_q[0].due != cycle_cnt) begin
          $display("Response in cycle %0d when no command was due", cycle_cnt);
          stop_on_error();
        end else begin
          exp_head = expect_q.pop_front();
          check_value("resp_o.exc", 64'(exp_head.resp.exc), 64'(resp_o.exc));
          check_value("resp_o.data", exp_head.resp.data, resp_o.data);
        end
      end
    end
  end

  initial begin
    row_s drain;
    logic prev_poison;
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_i            = '0;
    fill_v_i         = 1'b0;
    fill_i           = '0;
    poison_i         = 1'b0;
    priv_i           = e_priv_s;
    translation_en_i = 1'b0;
    sum_i            = 1'b0;
    drain            = '0;
    prev_poison      = 1'b0;
    load_vectors();
    cycle_limit = rows.size() + 20;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i], prev_poison);
      prev_poison = rows[i].poison;
      @(posedge clk_i);
      #2;
    end
    apply_row(drain, prev_poison);
    while (expect_q.size() != 0) begin
      @(posedge clk_i);
    end
    // Room for a stray late response
    repeat (2) @(posedge clk_i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
+incdir+testbench
design/mmu_pkg.sv
design/data_ram.sv
design/dtlb.sv
design/fault_check.sv
design/mem_ctrl.sv
design/mem_stage_top.sv
testbench/tb_mem_stage.sv

/* Makefile */
# Verilator flow for the memory stage testbench

TOP := tb_mem_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
